//--- bench/uart_tb.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

  import uart_cfg_pkg::*;
  import uart_status_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int BIT_CLKS      = 32;               // divisor 2, 16 ticks per bit
  localparam int FRAME_CLKS    = 13 * BIT_CLKS;    // longest frame with slack
  localparam int NUM_FRAMES    = 10;               // frames over all tests
  localparam int MARGIN_FRAMES = 10;
  localparam int TIMEOUT_NS    = (NUM_FRAMES + MARGIN_FRAMES) * FRAME_CLKS * CLK_PERIOD;
  localparam int WAIT_CLKS     = 2 * FRAME_CLKS;   // limit for one wait
  localparam logic [31:0] LFSR_SEED = 32'h020574c7;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

  logic                    clk;
  logic                    rst_n;
  uart_ctrl_t              ctrl;
  logic [`UART_DATA_W-1:0] tx_data;
  logic                    tx_write;
  logic                    rx_read;
  logic                    sr_read;
  logic                    rxd;
  logic [`UART_DATA_W-1:0] rx_data;
  uart_sr_t                status;
  logic                    txd;
  logic                    irq;
  logic [31:0]             lfsr;

  uart_top UUT (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .ctrl_i     (ctrl),
    .tx_data_i  (tx_data),
    .tx_write_i (tx_write),
    .rx_read_i  (rx_read),
    .sr_read_i  (sr_read),
    .rxd_i      (rxd),
    .rx_data_o  (rx_data),
    .status_o   (status),
    .txd_o      (txd),
    .irq_o      (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // whole run bounded by the frame budget
  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Testbench failed");
    $fatal(1, "watchdog timeout");
  end

  // ----------------------------------------------------------------------
  // helpers
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_TAPS;
    else
      return s >> 1;
  endfunction

  task automatic random_byte(output logic [7:0] b);
    int i;
    b = '0;
    for (i = 0; i < `UART_DATA_W; i++)
    begin
      b    = {lfsr[0], b[7:1]};   // one step per bit
      lfsr = next_lfsr(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Testbench failed");
    $fatal(1, "wait timeout");
  endtask

  task automatic wait_txd_fall();
    int n;
    n = 0;
    while (txd !== 1'b0)
    begin
      @(negedge clk);
      n = n + 1;
      if (n > WAIT_CLKS)
        give_up("txd_o never fell after the write");
    end
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (status.lsr.tx_idle !== 1'b1)
    begin
      @(negedge clk);
      n = n + 1;
      if (n > WAIT_CLKS)
        give_up("transmitter never went idle");
    end
  endtask

  task automatic wait_data_ready();
    int n;
    n = 0;
    while (status.lsr.data_ready !== 1'b1)
    begin
      @(negedge clk);
      n = n + 1;
      if (n > WAIT_CLKS)
        give_up("no received character showed up");
    end
  endtask

  task automatic write_tx_byte(input logic [7:0] b);
    @(posedge clk);
    tx_data  <= b;
    tx_write <= 1'b1;
    @(posedge clk);
    tx_write <= 1'b0;   // push on the fall
    @(posedge clk);     // data held through push cycle
  endtask

  task automatic pop_rx();
    @(posedge clk);
    rx_read <= 1'b1;
    @(posedge clk);
    rx_read <= 1'b0;
    repeat (2) @(posedge clk);   // pop, then registered flags
    @(negedge clk);
  endtask

  task automatic pulse_status_read();
    @(posedge clk);
    sr_read <= 1'b1;
    @(posedge clk);
    sr_read <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic drive_line(input logic level, input int clks);
    @(posedge clk);
    rxd <= level;
    repeat (clks - 1) @(posedge clk);
  endtask

  // one frame on rxd_i, format taken from the control word
  task automatic send_frame(input logic [7:0] b, input logic bad_parity, input logic bad_stop);
    logic [7:0] sh;
    logic       par;
    int         i;
    sh = b;
    drive_line(1'b0, BIT_CLKS);   // start
    for (i = 0; i < `UART_DATA_W; i++)
    begin
      drive_line(sh[0], BIT_CLKS);
      sh = sh >> 1;
    end
    par = (^b) ^ !ctrl.frame.even_parity ^ bad_parity;
    if (ctrl.frame.parity_en)
      drive_line(par, BIT_CLKS);
    if (bad_stop)
    begin
      drive_line(1'b0, BIT_CLKS / 2 + 8);              // low past the sample point
      drive_line(1'b1, BIT_CLKS + BIT_CLKS / 2 - 8);   // glitch start rejected here
    end
    else
      drive_line(1'b1, BIT_CLKS);
    if (ctrl.frame.two_stop)
      drive_line(1'b1, BIT_CLKS);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  task automatic test_reset();
    @(negedge clk);
    check_value("txd_o", 32'd1, 32'(txd));
    check_value("irq_o", 32'd0, 32'(irq));
    check_value("lsr.thr_empty", 32'd1, 32'(status.lsr.thr_empty));
    check_value("lsr.tx_idle", 32'd1, 32'(status.lsr.tx_idle));
    check_value("lsr.data_ready", 32'd0, 32'(status.lsr.data_ready));
    check_value("lsr.overrun", 32'd0, 32'(status.lsr.overrun));
    check_value("lsr.parity_err", 32'd0, 32'(status.lsr.parity_err));
    check_value("lsr.frame_err", 32'd0, 32'(status.lsr.frame_err));
    check_value("lsr.tx_overrun", 32'd0, 32'(status.lsr.tx_overrun));
    check_value("lsr.read_empty", 32'd0, 32'(status.lsr.read_empty));
    check_value("iir", 32'(IIR_NONE), 32'(status.iir));
    check_value("int_pending", 32'd0, 32'(status.int_pending));
  endtask

  task automatic test_transmit();
    logic [7:0]  b;
    logic [11:0] bits;   // start, data, parity, two stops
    int          i;
    random_byte(b);
    bits = {2'b11, ^b, b, 1'b0};
    @(posedge clk);
    ctrl.frame.parity_en   <= 1'b1;
    ctrl.frame.even_parity <= 1'b1;
    ctrl.frame.two_stop    <= 1'b1;
    ctrl.ier.thre          <= 1'b1;
    write_tx_byte(b);
    wait_txd_fall();
    repeat (BIT_CLKS / 2 - 1) @(negedge clk);   // middle of start bit
    for (i = 0; i < 12; i++)
    begin
      if (i != 0)
        repeat (BIT_CLKS) @(negedge clk);
      check_value("txd_o", 32'(bits[0]), 32'(txd));
      bits = bits >> 1;
    end
    wait_tx_idle();
    check_value("lsr.thr_empty", 32'd1, 32'(status.lsr.thr_empty));
    check_value("irq_o", 32'd1, 32'(irq));
    check_value("iir", 32'(IIR_THRE), 32'(status.iir));
    pulse_status_read();   // read also drops thre
    check_value("irq_o", 32'd0, 32'(irq));
    check_value("iir", 32'(IIR_NONE), 32'(status.iir));
    @(posedge clk);
    ctrl.ier.thre <= 1'b0;
  endtask

  task automatic test_receive();
    logic [7:0] b;
    logic [7:0] sent [$];
    int         i;
    @(posedge clk);
    ctrl.frame.parity_en <= 1'b0;
    ctrl.frame.two_stop  <= 1'b0;
    for (i = 0; i < 3; i++)
    begin
      random_byte(b);
      sent.push_back(b);
      send_frame(b, 1'b0, 1'b0);
    end
    for (i = 0; i < 3; i++)
    begin
      wait_data_ready();
      check_value("rx_data_o", 32'(sent.pop_front()), 32'(rx_data));
      pop_rx();
    end
    check_value("lsr.data_ready", 32'd0, 32'(status.lsr.data_ready));
    check_value("lsr.parity_err", 32'd0, 32'(status.lsr.parity_err));
    check_value("lsr.frame_err", 32'd0, 32'(status.lsr.frame_err));
    check_value("lsr.overrun", 32'd0, 32'(status.lsr.overrun));
  endtask

  task automatic test_errors();
    logic [7:0] b0;
    logic [7:0] b1;
    @(posedge clk);
    ctrl.frame.parity_en   <= 1'b1;
    ctrl.frame.even_parity <= 1'b1;
    ctrl.ier.rls           <= 1'b1;
    random_byte(b0);
    send_frame(b0, 1'b1, 1'b0);   // parity flipped
    wait_data_ready();
    @(negedge clk);
    check_value("lsr.parity_err", 32'd1, 32'(status.lsr.parity_err));
    check_value("lsr.frame_err", 32'd0, 32'(status.lsr.frame_err));
    check_value("irq_o", 32'd1, 32'(irq));
    check_value("iir", 32'(IIR_RLS), 32'(status.iir));
    random_byte(b1);
    send_frame(b1, 1'b0, 1'b1);   // stop bit low
    @(negedge clk);
    check_value("lsr.frame_err", 32'd1, 32'(status.lsr.frame_err));
    check_value("iir", 32'(IIR_RLS), 32'(status.iir));
    pulse_status_read();
    check_value("lsr.parity_err", 32'd0, 32'(status.lsr.parity_err));
    check_value("lsr.frame_err", 32'd0, 32'(status.lsr.frame_err));
    check_value("irq_o", 32'd0, 32'(irq));
    check_value("iir", 32'(IIR_NONE), 32'(status.iir));
    check_value("rx_data_o", 32'(b0), 32'(rx_data));   // data kept despite errors
    pop_rx();
    check_value("rx_data_o", 32'(b1), 32'(rx_data));
    pop_rx();
    check_value("lsr.data_ready", 32'd0, 32'(status.lsr.data_ready));
    @(posedge clk);
    ctrl.ier.rls <= 1'b0;
  endtask

  task automatic test_trigger_level();
    logic [7:0] b;
    logic [7:0] sent [$];
    int         i;
    @(posedge clk);
    ctrl.frame.parity_en <= 1'b0;
    ctrl.frame.two_stop  <= 1'b1;
    ctrl.trigger_level   <= 5'd4;
    ctrl.ier.rda         <= 1'b1;
    for (i = 0; i < 4; i++)
    begin
      random_byte(b);
      sent.push_back(b);
      send_frame(b, 1'b0, 1'b0);
      @(negedge clk);
      check_value("irq_o", (i == 3) ? 32'd1 : 32'd0, 32'(irq));   // only at the fourth
    end
    check_value("iir", 32'(IIR_RDA), 32'(status.iir));
    check_value("rx_data_o", 32'(sent.pop_front()), 32'(rx_data));
    pop_rx();
    check_value("irq_o", 32'd0, 32'(irq));
    check_value("iir", 32'(IIR_NONE), 32'(status.iir));
    for (i = 0; i < 3; i++)
    begin
      check_value("rx_data_o", 32'(sent.pop_front()), 32'(rx_data));
      pop_rx();
    end
    @(posedge clk);
    ctrl.ier.rda <= 1'b0;
  endtask

  task automatic test_overruns();
    logic [7:0] b;
    int         i;
    @(posedge clk);
    ctrl.divisor <= 12'hFFF;   // at most one pop during the burst
    repeat (4) @(posedge clk);
    for (i = 0; i < 18; i++)
    begin
      random_byte(b);
      write_tx_byte(b);
    end
    @(negedge clk);
    check_value("lsr.tx_overrun", 32'd1, 32'(status.lsr.tx_overrun));
    pop_rx();                  // rx fifo is empty here
    check_value("lsr.read_empty", 32'd1, 32'(status.lsr.read_empty));
    check_value("irq_o", 32'd0, 32'(irq));
    pulse_status_read();
    check_value("lsr.tx_overrun", 32'd0, 32'(status.lsr.tx_overrun));
    check_value("lsr.read_empty", 32'd0, 32'(status.lsr.read_empty));
    check_value("lsr.thr_empty", 32'd0, 32'(status.lsr.thr_empty));   // bytes still queued
    @(posedge clk);
    ctrl.tx_fifo_clr <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_value("lsr.thr_empty", 32'd1, 32'(status.lsr.thr_empty));   // cleared queue
    @(posedge clk);
    ctrl.tx_fifo_clr <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  initial
  begin
    lfsr               = LFSR_SEED;
    rst_n              <= 1'b0;
    ctrl               <= '0;
    ctrl.divisor       <= 12'd2;
    ctrl.trigger_level <= 5'd1;
    tx_data            <= '0;
    tx_write           <= 1'b0;
    rx_read            <= 1'b0;
    sr_read            <= 1'b0;
    rxd                <= 1'b1;   // idle line
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset();
    test_transmit();
    test_receive();
    test_errors();
    test_trigger_level();
    test_overruns();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+include
rtl/uart_cfg_pkg.sv
rtl/uart_status_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_sync_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_status_irq.sv
rtl/uart_top.sv
bench/uart_tb.sv

//--- include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// character format
`define UART_DATA_W      8   // data bits per character, fixed
`define UART_OVERSAMPLE  16  // baud ticks per bit

// baud generator
`define UART_DIV_W       12  // clocks per tick

// both fifos
`define UART_FIFO_DEPTH  16
`define UART_FIFO_CNT_W  5   // holds 0..depth

`endif

//--- rtl/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_baud_gen (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`UART_DIV_W-1:0] divisor_i,
  output logic                   baud_tick_o
);

  logic [`UART_DIV_W-1:0] cnt_q;  // counts down to zero

  always_ff @(posedge clk)
  begin
    if (!rst_n_i || divisor_i == '0)
      cnt_q <= '0;                    // parked while stopped
    else if (cnt_q == '0)
      cnt_q <= divisor_i - 1'b1;      // reload, period is divisor clocks
    else
      cnt_q <= cnt_q - 1'b1;
  end

  // tick on zero, never with a zero divisor
  assign baud_tick_o = (divisor_i != '0) && (cnt_q == '0);

  // reload keeps ticks apart once the divisor exceeds one
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (baud_tick_o && divisor_i > 1) |=> !baud_tick_o);

endmodule

//--- rtl/uart_cfg_pkg.sv
`include "uart_defines.svh"

package uart_cfg_pkg;

  // frame format, word length is always 8
  typedef struct packed {
    logic parity_en;    // parity bit after the data
    logic even_parity;  // 0 selects odd
    logic two_stop;
  } frame_cfg_t;

  // interrupt enables
  typedef struct packed {
    logic rls;   // receiver line status
    logic rda;   // rx data at trigger level
    logic thre;  // tx fifo went empty
  } ier_t;

  // host control word, held as a level
  typedef struct packed {
    logic [`UART_DIV_W-1:0]      divisor;        // zero stops the ticks
    frame_cfg_t                  frame;
    ier_t                        ier;
    logic                        tx_fifo_clr;    // held count at zero
    logic                        rx_fifo_clr;
    logic [`UART_FIFO_CNT_W-1:0] trigger_level;  // rda threshold
  } uart_ctrl_t;

endpackage

//--- rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        baud_tick_i,
  input  uart_cfg_pkg::frame_cfg_t    frame_i,
  input  logic                        fifo_clr_i,
  input  logic                        rxd_i,
  input  logic                        rx_read_i,
  output logic [`UART_DATA_W-1:0]     rx_data_o,
  output logic [`UART_FIFO_CNT_W-1:0] rx_count_o,
  output uart_status_pkg::line_evt_t  evt_o
);

  import uart_status_pkg::*;

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_DATA_W);
  localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`UART_DATA_W - 1);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  rx_state_e               state_q;
  logic                    rxd_meta_q;
  logic                    rxd_s_q;     // synchronized line
  logic [TICK_W-1:0]       tick_cnt_q;
  logic [BIT_W-1:0]        bit_cnt_q;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    par_acc_q;   // running xor of data bits
  logic                    par_err_q;
  logic                    rd_d_q;
  logic                    rd_fall;
  logic                    sample;
  logic                    fifo_push;
  logic                    fifo_full;
  logic                    fifo_empty;
  rx_char_t                fifo_wdata;
  rx_char_t                fifo_rdata;

  // ----------------------------------------------------------------------
  // deserializer, bit centers are 16 ticks apart after the start check
  assign sample    = baud_tick_i && (tick_cnt_q == LAST_TICK);
  assign fifo_push = sample && (state_q == RX_STOP);  // middle of first stop bit

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      rxd_meta_q <= 1'b1;
      rxd_s_q    <= 1'b1;
      rd_d_q     <= 1'b0;
      state_q    <= RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end
    else
    begin
      rxd_meta_q <= rxd_i;
      rxd_s_q    <= rxd_meta_q;
      rd_d_q     <= rx_read_i;
      if (baud_tick_i)
        tick_cnt_q <= tick_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE:
          if (!rxd_s_q)
          begin
            state_q    <= RX_START;
            tick_cnt_q <= '0;
          end
        RX_START:
          if (baud_tick_i && tick_cnt_q == MID_TICK)
          begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= rxd_s_q ? RX_IDLE : RX_DATA;  // high again means a glitch
          end
        RX_DATA:
          if (sample)
          begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == LAST_BIT)
              state_q <= frame_i.parity_en ? RX_PARITY : RX_STOP;
          end
        RX_PARITY:
          if (sample)
            state_q <= RX_STOP;
        RX_STOP:
          if (sample)
            state_q <= RX_IDLE;   // second stop bit is not checked
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == RX_START)
    begin
      par_acc_q <= 1'b0;
      par_err_q <= 1'b0;
    end
    if (sample && state_q == RX_DATA)
    begin
      shift_q   <= {rxd_s_q, shift_q[`UART_DATA_W-1:1]};  // lsb arrives first
      par_acc_q <= par_acc_q ^ rxd_s_q;
    end
    if (sample && state_q == RX_PARITY)
      par_err_q <= par_acc_q ^ rxd_s_q ^ !frame_i.even_parity;
  end

  // ----------------------------------------------------------------------
  // receive fifo and host read
  assign rd_fall = rd_d_q && !rx_read_i;

  always_comb
  begin
    fifo_wdata.data       = shift_q;
    fifo_wdata.parity_err = par_err_q;
    fifo_wdata.frame_err  = !rxd_s_q;
  end

  uart_sync_fifo #(.payload_t(rx_char_t)) u_rx_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .clr_i   (fifo_clr_i),
    .push_i  (fifo_push),
    .pop_i   (rd_fall),
    .wdata_i (fifo_wdata),
    .rdata_o (fifo_rdata),
    .count_o (rx_count_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  assign rx_data_o = fifo_rdata.data;  // head byte

  always_comb
  begin
    evt_o               = '0;
    evt_o.rx_overrun    = fifo_push && fifo_full;
    evt_o.rx_parity_err = fifo_push && par_err_q;
    evt_o.rx_frame_err  = fifo_push && !rxd_s_q;
    evt_o.rx_read_empty = rd_fall && fifo_empty;
  end

  // a pop on an empty fifo must not eat the character pushed alongside
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (fifo_empty && fifo_push && rd_fall && !fifo_clr_i) |=> (rx_count_o == 1));

endmodule

//--- rtl/uart_status_irq.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_status_irq (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  uart_status_pkg::line_evt_t  evt_i,
  input  logic [`UART_FIFO_CNT_W-1:0] rx_count_i,
  input  logic                        tx_fifo_empty_i,
  input  logic                        tx_idle_i,
  input  uart_cfg_pkg::ier_t          ier_i,
  input  logic [`UART_FIFO_CNT_W-1:0] trigger_level_i,
  input  logic                        tx_write_i,
  input  logic                        sr_read_i,
  output uart_status_pkg::uart_sr_t   status_o,
  output logic                        irq_o
);

  import uart_status_pkg::*;

  line_evt_t evt_d_q;       // events one cycle back
  line_evt_t evt_rise;
  line_evt_t sticky_q;
  logic      sr_d_q;
  logic      lsr_clr;       // falling edge of status read
  logic      rls_int;
  logic      rls_int_d_q;
  logic      thre_int;
  logic      thre_int_d_q;
  logic      rls_pnd_q;
  logic      rda_pnd_q;
  logic      thre_pnd_q;

  assign evt_rise = evt_i & ~evt_d_q;
  assign lsr_clr  = sr_d_q && !sr_read_i;
  assign rls_int  = ier_i.rls && (|sticky_q);
  assign thre_int = ier_i.thre && tx_fifo_empty_i;

  // ----------------------------------------------------------------------
  // sticky bits and pending flags
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      evt_d_q      <= '0;
      sticky_q     <= '0;
      sr_d_q       <= 1'b0;
      rls_int_d_q  <= 1'b0;
      thre_int_d_q <= 1'b1;   // no thre rise straight out of reset
      rls_pnd_q    <= 1'b0;
      rda_pnd_q    <= 1'b0;
      thre_pnd_q   <= 1'b0;
    end
    else
    begin
      evt_d_q      <= evt_i;
      sr_d_q       <= sr_read_i;
      rls_int_d_q  <= rls_int;
      thre_int_d_q <= thre_int;
      sticky_q     <= lsr_clr ? '0 : (sticky_q | evt_rise);

      if (lsr_clr)
        rls_pnd_q <= 1'b0;
      else if (rls_int && !rls_int_d_q)
        rls_pnd_q <= 1'b1;
      else
        rls_pnd_q <= rls_pnd_q && ier_i.rls;   // masked drops it

      rda_pnd_q <= ier_i.rda && (rx_count_i >= trigger_level_i);  // level

      if (tx_write_i || sr_read_i)
        thre_pnd_q <= 1'b0;
      else if (thre_int && !thre_int_d_q)
        thre_pnd_q <= 1'b1;
      else
        thre_pnd_q <= thre_pnd_q && ier_i.thre;
    end
  end

  // ----------------------------------------------------------------------
  // status word and id by priority
  assign irq_o = rls_pnd_q || rda_pnd_q || thre_pnd_q;

  always_comb
  begin
    status_o.lsr.data_ready = (rx_count_i != '0);
    status_o.lsr.overrun    = sticky_q.rx_overrun;
    status_o.lsr.parity_err = sticky_q.rx_parity_err;
    status_o.lsr.frame_err  = sticky_q.rx_frame_err;
    status_o.lsr.thr_empty  = tx_fifo_empty_i;
    status_o.lsr.tx_idle    = tx_idle_i;
    status_o.lsr.tx_overrun = sticky_q.tx_overrun;
    status_o.lsr.read_empty = sticky_q.rx_read_empty;
    if (rls_pnd_q)
      status_o.iir = IIR_RLS;
    else if (rda_pnd_q)
      status_o.iir = IIR_RDA;
    else if (thre_pnd_q)
      status_o.iir = IIR_THRE;
    else
      status_o.iir = IIR_NONE;
    status_o.int_pending = irq_o;
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    irq_o == (status_o.iir != IIR_NONE));

endmodule

//--- rtl/uart_status_pkg.sv
`include "uart_defines.svh"

package uart_status_pkg;

  // one entry of the receive fifo
  typedef struct packed {
    logic [`UART_DATA_W-1:0] data;
    logic                    parity_err;
    logic                    frame_err;   // stop bit seen low
  } rx_char_t;

  // single cycle event pulses toward the status block
  typedef struct packed {
    logic rx_overrun;
    logic rx_parity_err;
    logic rx_frame_err;
    logic rx_read_empty;  // pop on an empty rx fifo
    logic tx_overrun;     // push on a full tx fifo
  } line_evt_t;

  // line status
  typedef struct packed {
    logic data_ready;
    logic overrun;
    logic parity_err;
    logic frame_err;
    logic thr_empty;
    logic tx_idle;
    logic tx_overrun;
    logic read_empty;
  } lsr_t;

  // interrupt id, same codes as the 16550 family
  typedef enum logic [2:0] {
    IIR_NONE = 3'b000,
    IIR_RLS  = 3'b011,
    IIR_RDA  = 3'b010,
    IIR_THRE = 3'b001
  } iir_e;

  typedef struct packed {
    lsr_t lsr;
    iir_e iir;
    logic int_pending;  // active high
  } uart_sr_t;

endpackage

//--- rtl/uart_sync_fifo.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_sync_fifo #(
  parameter type payload_t = logic [`UART_DATA_W-1:0]
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        clr_i,
  input  logic                        push_i,
  input  logic                        pop_i,
  input  payload_t                    wdata_i,
  output payload_t                    rdata_o,
  output logic [`UART_FIFO_CNT_W-1:0] count_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);
  localparam logic [`UART_FIFO_CNT_W-1:0] FULL_CNT = `UART_FIFO_DEPTH;

  payload_t         mem_q [`UART_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_o == FULL_CNT);
  assign empty_o = (count_o == '0);
  assign do_push = push_i && !full_o;   // dropped when full
  assign do_pop  = pop_i && !empty_o;   // ignored when empty
  assign rdata_o = mem_q[rd_ptr_q];     // head, no read latency

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= wdata_i;
  end

  // pointers wrap at the power of two depth
  always_ff @(posedge clk)
  begin
    if (!rst_n_i || clr_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;        // both or neither
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i) count_o <= FULL_CNT);

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  uart_cfg_pkg::uart_ctrl_t  ctrl_i,
  input  logic [`UART_DATA_W-1:0]   tx_data_i,
  input  logic                      tx_write_i,
  input  logic                      rx_read_i,
  input  logic                      sr_read_i,
  input  logic                      rxd_i,
  output logic [`UART_DATA_W-1:0]   rx_data_o,
  output uart_status_pkg::uart_sr_t status_o,
  output logic                      txd_o,
  output logic                      irq_o
);

  import uart_status_pkg::*;

  logic                        baud_tick;
  logic                        tx_fifo_empty;
  logic                        tx_idle;
  logic [`UART_FIFO_CNT_W-1:0] rx_count;
  line_evt_t                   tx_evt;
  line_evt_t                   rx_evt;
  line_evt_t                   line_evt;

  assign line_evt = tx_evt | rx_evt;  // each side drives its own bits

  uart_baud_gen u_baud_gen (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .divisor_i   (ctrl_i.divisor),
    .baud_tick_o (baud_tick)
  );

  uart_tx u_tx (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .baud_tick_i     (baud_tick),
    .frame_i         (ctrl_i.frame),
    .fifo_clr_i      (ctrl_i.tx_fifo_clr),
    .tx_data_i       (tx_data_i),
    .tx_write_i      (tx_write_i),
    .txd_o           (txd_o),
    .tx_fifo_empty_o (tx_fifo_empty),
    .tx_idle_o       (tx_idle),
    .evt_o           (tx_evt)
  );

  uart_rx u_rx (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .baud_tick_i (baud_tick),
    .frame_i     (ctrl_i.frame),
    .fifo_clr_i  (ctrl_i.rx_fifo_clr),
    .rxd_i       (rxd_i),
    .rx_read_i   (rx_read_i),
    .rx_data_o   (rx_data_o),
    .rx_count_o  (rx_count),
    .evt_o       (rx_evt)
  );

  uart_status_irq u_status_irq (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .evt_i           (line_evt),
    .rx_count_i      (rx_count),
    .tx_fifo_empty_i (tx_fifo_empty),
    .tx_idle_i       (tx_idle),
    .ier_i           (ctrl_i.ier),
    .trigger_level_i (ctrl_i.trigger_level),
    .tx_write_i      (tx_write_i),
    .sr_read_i       (sr_read_i),
    .status_o        (status_o),
    .irq_o           (irq_o)
  );

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       baud_tick_i,
  input  uart_cfg_pkg::frame_cfg_t   frame_i,
  input  logic                       fifo_clr_i,
  input  logic [`UART_DATA_W-1:0]    tx_data_i,
  input  logic                       tx_write_i,
  output logic                       txd_o,
  output logic                       tx_fifo_empty_o,
  output logic                       tx_idle_o,
  output uart_status_pkg::line_evt_t evt_o
);

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_DATA_W);
  localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`UART_DATA_W - 1);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  tx_state_e               state_q;
  logic [TICK_W-1:0]       tick_cnt_q;
  logic [BIT_W-1:0]        bit_cnt_q;
  logic [`UART_DATA_W-1:0] shift_q;
  logic [`UART_DATA_W-1:0] fifo_rdata;
  logic                    par_bit_q;
  logic                    stop2_q;     // second stop bit running
  logic                    wr_d_q;
  logic                    wr_fall;
  logic                    fifo_full;
  logic                    fifo_pop;
  logic                    bit_done;

  // ----------------------------------------------------------------------
  // host write, acts on the falling edge of the strobe
  assign wr_fall = wr_d_q && !tx_write_i;

  always_comb
  begin
    evt_o            = '0;
    evt_o.tx_overrun = wr_fall && fifo_full;  // byte dropped
  end

  uart_sync_fifo #(.payload_t(logic [`UART_DATA_W-1:0])) u_tx_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .clr_i   (fifo_clr_i),
    .push_i  (wr_fall),
    .pop_i   (fifo_pop),
    .wdata_i (tx_data_i),
    .rdata_o (fifo_rdata),
    .count_o (),
    .full_o  (fifo_full),
    .empty_o (tx_fifo_empty_o)
  );

  // ----------------------------------------------------------------------
  // serializer, frames start on a tick so every bit is 16 ticks
  assign fifo_pop  = (state_q == TX_IDLE) && baud_tick_i && !tx_fifo_empty_o;
  assign bit_done  = baud_tick_i && (tick_cnt_q == LAST_TICK);
  assign tx_idle_o = tx_fifo_empty_o && (state_q == TX_IDLE);

  always_ff @(posedge clk)
  begin
    if (fifo_pop)
    begin
      shift_q   <= fifo_rdata;
      par_bit_q <= (^fifo_rdata) ^ !frame_i.even_parity;  // even gives even ones
    end
    else if (state_q == TX_DATA && bit_done)
      shift_q <= shift_q >> 1;     // lsb first
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q    <= TX_IDLE;
      txd_o      <= 1'b1;   // line idles high
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      stop2_q    <= 1'b0;
      wr_d_q     <= 1'b0;
    end
    else
    begin
      wr_d_q <= tx_write_i;
      if (baud_tick_i)
        tick_cnt_q <= tick_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE:
          if (fifo_pop)
          begin
            state_q    <= TX_START;
            txd_o      <= 1'b0;
            tick_cnt_q <= '0;
          end
        TX_START:
          if (bit_done)
          begin
            state_q   <= TX_DATA;
            txd_o     <= shift_q[0];
            bit_cnt_q <= '0;
          end
        TX_DATA:
          if (bit_done)
          begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q != LAST_BIT)
              txd_o <= shift_q[1];   // shifter moves on this edge
            else if (frame_i.parity_en)
            begin
              state_q <= TX_PARITY;
              txd_o   <= par_bit_q;
            end
            else
            begin
              state_q <= TX_STOP;
              txd_o   <= 1'b1;
              stop2_q <= 1'b0;
            end
          end
        TX_PARITY:
          if (bit_done)
          begin
            state_q <= TX_STOP;
            txd_o   <= 1'b1;
            stop2_q <= 1'b0;
          end
        TX_STOP:
          if (bit_done)
          begin
            if (frame_i.two_stop && !stop2_q)
              stop2_q <= 1'b1;
            else
              state_q <= TX_IDLE;
          end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i) (state_q == TX_IDLE) |-> txd_o);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the uart testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module uart_tb -o uart_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/uart_tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
